// ==== list.f ====
+incdir+rtl
rtl/mem_pkg.sv
rtl/main_memory.sv
rtl/mem_arbiter.sv
rtl/icache.sv
rtl/dcache.sv
rtl/mem_subsystem.sv
sim/clk_gen.sv
sim/mem_subsystem_asserts.sv
sim/mem_subsystem_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vmem_subsystem_tb

.PHONY: all run clean

all: run

$(SIM): list.f $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module mem_subsystem_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"
`default_nettype none

module mem_subsystem_tb;

  localparam int TIMEOUT_CYCLES = 100;
  localparam int LINE_WORDS     = `LINE_W / `WORD_W;
  localparam int MODEL_WORDS    = `MEM_BYTES / (`WORD_W / 8);

  typedef enum logic [2:0] {
    op_idle,
    op_fetch,
    op_data,
    op_flush,
    op_pair
  } op_t;

  // One table row, addr2 is the data port address of a paired step
  // and value is either fixed store data or an idle cycle count
  typedef struct packed {
    op_t                    op;
    logic                   we;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_ADDR_W-1:0] addr2;
    logic                   rnd;
    mem_pkg::word_t         value;
  } step_t;

  logic               clk;
  logic               rst;
  logic               fetch_req;
  mem_pkg::mem_addr_t fetch_addr;
  logic               flush;
  logic               fetch_valid;
  mem_pkg::word_t     fetch_word;
  logic               data_req;
  logic               data_we;
  mem_pkg::mem_addr_t data_addr;
  mem_pkg::word_t     data_wdata;
  logic               data_valid;
  mem_pkg::word_t     data_rdata;

  step_t steps [$];

  // Memory contents as seen through the data port, one entry per word
  mem_pkg::word_t model [MODEL_WORDS];

  // Expected instruction cache contents
  logic           ic_valid [`CACHE_LINES];
  mem_pkg::tag_t  ic_tag   [`CACHE_LINES];
  mem_pkg::word_t ic_data  [`CACHE_LINES][LINE_WORDS];

  logic [31:0] lfsr_state;
  logic        passed;
  logic        failure_reported;

  clk_gen clk_gen_i (
    .clk(clk),
    .rst(rst)
  );

  mem_subsystem mem_subsystem_i (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .flush      (flush),
    .fetch_valid(fetch_valid),
    .fetch_word (fetch_word),
    .data_req   (data_req),
    .data_we    (data_we),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_valid (data_valid),
    .data_rdata (data_rdata)
  );

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0])
    begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // One LFSR step per data bit
  task automatic random_word(output mem_pkg::word_t w);
    for (int i = 0; i < `WORD_W; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      w[i] = lfsr_state[0];
    end
  endtask

  task automatic stop_on_error(input string why);
    failure_reported = 1'b1;
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input mem_pkg::word_t got, input mem_pkg::word_t expected,
                            input string what);
    if (got !== expected)
    begin
      stop_on_error($sformatf("mismatch at time %0t: %s returned %h, expected %h",
                              $time, what, got, expected));
    end
  endtask

  task automatic check_idle(input int cycles);
    for (int n = 0; n < cycles; n++)
    begin
      @(posedge clk);
      #1;
      if ((fetch_valid !== 1'b0) || (data_valid !== 1'b0))
      begin
        stop_on_error($sformatf("A valid pulse appeared at time %0t with no request", $time));
      end
    end
  endtask

  task automatic add_step(input op_t op, input logic we, input logic [`MEM_ADDR_W-1:0] addr,
                          input logic [`MEM_ADDR_W-1:0] addr2, input logic rnd,
                          input mem_pkg::word_t value);
    step_t s;
    s.op    = op;
    s.we    = we;
    s.addr  = addr;
    s.addr2 = addr2;
    s.rnd   = rnd;
    s.value = value;
    steps.push_back(s);
  endtask

  // Request level held until the one-cycle valid, then dropped
  task automatic run_fetch(input mem_pkg::mem_addr_t addr, output mem_pkg::word_t word);
    int n;
    fetch_req  = 1'b1;
    fetch_addr = addr;
    for (n = 0; n < TIMEOUT_CYCLES; n++)
    begin
      @(posedge clk);
      #1;
      if (fetch_valid)
      begin
        break;
      end
    end
    if (n == TIMEOUT_CYCLES)
    begin
      stop_on_error($sformatf("Timeout: fetch_valid never came for address %h", addr));
    end
    word      = fetch_word;
    fetch_req = 1'b0;
  endtask

  task automatic run_data(input logic we, input mem_pkg::mem_addr_t addr,
                          input mem_pkg::word_t wdata, output mem_pkg::word_t rdata);
    int n;
    data_req   = 1'b1;
    data_we    = we;
    data_addr  = addr;
    data_wdata = wdata;
    for (n = 0; n < TIMEOUT_CYCLES; n++)
    begin
      @(posedge clk);
      #1;
      if (data_valid)
      begin
        break;
      end
    end
    if (n == TIMEOUT_CYCLES)
    begin
      stop_on_error($sformatf("Timeout: data_valid never came for address %h", addr));
    end
    rdata    = data_rdata;
    data_req = 1'b0;
    data_we  = 1'b0;
  endtask

  // Direct-mapped lookup, a miss loads the whole line from the word model
  task automatic predict_fetch(input mem_pkg::mem_addr_t a, output mem_pkg::word_t expected);
    mem_pkg::index_t idx;
    int              base;
    idx  = a.cache_view.index;
    base = int'(a.line_view.line) * LINE_WORDS;
    if (!ic_valid[idx] || (ic_tag[idx] != a.cache_view.tag))
    begin
      for (int w = 0; w < LINE_WORDS; w++)
      begin
        ic_data[idx][w] = model[base + w];
      end
      ic_valid[idx] = 1'b1;
      ic_tag[idx]   = a.cache_view.tag;
    end
    expected = ic_data[idx][a.cache_view.offset[`OFFSET_W-1 -: `WORD_SEL_W]];
  endtask

  task automatic apply_step(input step_t s);
    mem_pkg::word_t wdata;
    mem_pkg::word_t got;
    mem_pkg::word_t got2;
    mem_pkg::word_t expected;
    mem_pkg::word_t expected2;
    case (s.op)
      op_idle:
      begin
        check_idle(int'(s.value));
      end
      op_fetch:
      begin
        predict_fetch(s.addr, expected);
        run_fetch(s.addr, got);
        check_word(got, expected, $sformatf("fetch from %h", s.addr));
      end
      op_data:
      begin
        if (s.we)
        begin
          wdata = s.value;
          if (s.rnd)
          begin
            random_word(wdata);
          end
          model[int'(s.addr >> 2)] = wdata;
          run_data(1'b1, s.addr, wdata, got);
        end
        else
        begin
          run_data(1'b0, s.addr, '0, got);
          check_word(got, model[int'(s.addr >> 2)], $sformatf("load from %h", s.addr));
        end
      end
      op_flush:
      begin
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        for (int i = 0; i < `CACHE_LINES; i++)
        begin
          ic_valid[i] = 1'b0;
        end
      end
      op_pair:
      begin
        // Both ports request in the same cycle
        predict_fetch(s.addr, expected);
        expected2 = model[int'(s.addr2 >> 2)];
        fork
          run_fetch(s.addr, got);
          run_data(1'b0, s.addr2, '0, got2);
        join
        check_word(got, expected, $sformatf("paired fetch from %h", s.addr));
        check_word(got2, expected2, $sformatf("paired load from %h", s.addr2));
      end
      default:
      begin
        stop_on_error("The stimulus table holds an unknown step");
      end
    endcase
  endtask

  task automatic build_table();
    // Nothing moves while no request is applied
    add_step(op_idle,  1'b0, 12'h000, 12'h000, 1'b0, 32'd12);
    // Fill one line word by word, then read back and rewrite one word
    add_step(op_data,  1'b1, 12'h040, 12'h000, 1'b1, 32'h0);
    add_step(op_data,  1'b1, 12'h044, 12'h000, 1'b0, 32'h1234_5678);
    add_step(op_data,  1'b1, 12'h048, 12'h000, 1'b1, 32'h0);
    add_step(op_data,  1'b1, 12'h04c, 12'h000, 1'b1, 32'h0);
    add_step(op_data,  1'b0, 12'h044, 12'h000, 1'b0, 32'h0);
    add_step(op_data,  1'b0, 12'h040, 12'h000, 1'b0, 32'h0);
    add_step(op_data,  1'b0, 12'h04c, 12'h000, 1'b0, 32'h0);
    add_step(op_data,  1'b1, 12'h044, 12'h000, 1'b1, 32'h0);
    add_step(op_data,  1'b0, 12'h044, 12'h000, 1'b0, 32'h0);
    add_step(op_data,  1'b0, 12'h048, 12'h000, 1'b0, 32'h0);
    // Index 1 with tags 2 and 3 evicts back and forth
    add_step(op_data,  1'b1, 12'h090, 12'h000, 1'b1, 32'h0);
    add_step(op_data,  1'b1, 12'h0d0, 12'h000, 1'b0, 32'h5a5a_00d0);
    add_step(op_data,  1'b0, 12'h090, 12'h000, 1'b0, 32'h0);
    add_step(op_data,  1'b0, 12'h0d0, 12'h000, 1'b0, 32'h0);
    add_step(op_data,  1'b1, 12'h094, 12'h000, 1'b1, 32'h0);
    add_step(op_data,  1'b0, 12'h090, 12'h000, 1'b0, 32'h0);
    // Icache keeps a stale line until flushed
    add_step(op_data,  1'b1, 12'h120, 12'h000, 1'b1, 32'h0);
    add_step(op_data,  1'b1, 12'h124, 12'h000, 1'b1, 32'h0);
    add_step(op_fetch, 1'b0, 12'h120, 12'h000, 1'b0, 32'h0);
    add_step(op_data,  1'b1, 12'h120, 12'h000, 1'b1, 32'h0);
    add_step(op_fetch, 1'b0, 12'h120, 12'h000, 1'b0, 32'h0);
    add_step(op_fetch, 1'b0, 12'h124, 12'h000, 1'b0, 32'h0);
    add_step(op_flush, 1'b0, 12'h000, 12'h000, 1'b0, 32'h0);
    add_step(op_fetch, 1'b0, 12'h120, 12'h000, 1'b0, 32'h0);
    // Two misses fight for the arbiter, then a miss against a hit
    add_step(op_pair,  1'b0, 12'h048, 12'h0d0, 1'b0, 32'h0);
    add_step(op_pair,  1'b0, 12'h094, 12'h040, 1'b0, 32'h0);
    add_step(op_pair,  1'b0, 12'h044, 12'h0d0, 1'b0, 32'h0);
    add_step(op_idle,  1'b0, 12'h000, 12'h000, 1'b0, 32'd6);
  endtask

  initial
  begin
    int n;
    passed           = 1'b0;
    failure_reported = 1'b0;
    lfsr_state       = 32'h69ea;
    fetch_req        = 1'b0;
    fetch_addr       = '0;
    flush            = 1'b0;
    data_req         = 1'b0;
    data_we          = 1'b0;
    data_addr        = '0;
    data_wdata       = '0;
    for (int i = 0; i < `CACHE_LINES; i++)
    begin
      ic_valid[i] = 1'b0;
    end
    build_table();
    for (n = 0; n < 64; n++)
    begin
      @(posedge clk);
      if (!rst)
      begin
        break;
      end
    end
    if (n == 64)
    begin
      stop_on_error("Reset was never released");
    end
    #1;
    foreach (steps[i])
    begin
      apply_step(steps[i]);
    end
    passed = 1'b1;
    $display("TESTS PASSED");
    $finish;
  end

  final
  begin
    if (!passed && !failure_reported)
    begin
      $display("TESTS FAILED");
    end
  end

endmodule

`default_nettype wire

// ==== sim/mem_subsystem_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_asserts (
  input logic clk,
  input logic rst,
  input logic enable,
  input logic ready,
  input logic taken_a,
  input logic taken_b
);

  // Ready is a single-cycle pulse
  ready_one_cycle: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
    else $error("ready stayed high for more than one cycle");

  // Every pulse is taken by exactly one side that still holds the access
  ready_taken: assert property (@(posedge clk) disable iff (rst) ready |-> (taken_a ^ taken_b))
    else $error("ready was not taken by exactly one side");

  // Enable was seen three cycles before every new pulse
  ready_latency: assert property (@(posedge clk) disable iff (rst) $rose(ready) |-> $past(enable, 3))
    else $error("ready came without enable three cycles earlier");

  // Enable is a level that holds until ready
  enable_held: assert property (@(posedge clk) disable iff (rst) (enable && !ready) |=> enable)
    else $error("enable dropped before ready");

  // The grant is given up for one cycle after every access
  release_cycle: assert property (@(posedge clk) disable iff (rst) ready |=> !enable)
    else $error("enable was high in the release cycle");

endmodule

// The arbiter hands each memory pulse to the icache or to the dcache
bind mem_arbiter mem_subsystem_asserts arbiter_checks_i (
  .clk    (clk),
  .rst    (rst),
  .enable (mem_enable),
  .ready  (mem_data_ready),
  .taken_a(i_ready),
  .taken_b(d_ready)
);

// The memory expects its requester to stay enabled through the pulse
bind main_memory mem_subsystem_asserts memory_checks_i (
  .clk    (clk),
  .rst    (rst),
  .enable (enable),
  .ready  (data_ready),
  .taken_a(enable),
  .taken_b(1'b0)
);

`default_nettype wire

// ==== sim/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rst
);

  // Free-running clock with an 8 ns period
  initial
  begin
    clk = 1'b0;
    forever
    begin
      #4 clk = ~clk;
    end
  end

  // Reset is high for the first eight rising edges and drops 1 ns after the last
  initial
  begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== rtl/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
  input  logic               clk,
  input  logic               rst,
  // Instruction fetch port
  input  logic               fetch_req,
  input  mem_pkg::mem_addr_t fetch_addr,
  input  logic               flush,
  output logic               fetch_valid,
  output mem_pkg::word_t     fetch_word,
  // Load and store port
  input  logic               data_req,
  input  logic               data_we,
  input  mem_pkg::mem_addr_t data_addr,
  input  mem_pkg::word_t     data_wdata,
  output logic               data_valid,
  output mem_pkg::word_t     data_rdata
);

  // Instruction cache to arbiter
  wire                     ic_mem_req;
  wire mem_pkg::mem_addr_t ic_mem_addr;
  wire mem_pkg::line_t     ic_mem_rline;
  wire                     ic_mem_ready;

  // Data cache to arbiter
  wire                     dc_mem_req;
  wire                     dc_mem_we;
  wire mem_pkg::mem_addr_t dc_mem_addr;
  wire mem_pkg::line_t     dc_mem_wline;
  wire mem_pkg::line_t     dc_mem_rline;
  wire                     dc_mem_ready;

  // Arbiter to main memory
  wire                     mem_enable;
  wire                     mem_op;
  wire mem_pkg::mem_addr_t mem_address;
  wire mem_pkg::line_t     mem_data_in;
  wire mem_pkg::line_t     mem_data_out;
  wire                     mem_data_ready;

  icache icache_i (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .flush      (flush),
    .fetch_valid(fetch_valid),
    .fetch_word (fetch_word),
    .mem_req    (ic_mem_req),
    .mem_addr   (ic_mem_addr),
    .mem_rline  (ic_mem_rline),
    .mem_ready  (ic_mem_ready)
  );

  dcache dcache_i (
    .clk        (clk),
    .rst        (rst),
    .data_req   (data_req),
    .data_we    (data_we),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_valid (data_valid),
    .data_rdata (data_rdata),
    .mem_req    (dc_mem_req),
    .mem_we     (dc_mem_we),
    .mem_addr   (dc_mem_addr),
    .mem_wline  (dc_mem_wline),
    .mem_rline  (dc_mem_rline),
    .mem_ready  (dc_mem_ready)
  );

  mem_arbiter mem_arbiter_i (
    .clk           (clk),
    .rst           (rst),
    .i_req         (ic_mem_req),
    .i_addr        (ic_mem_addr),
    .i_line        (ic_mem_rline),
    .i_ready       (ic_mem_ready),
    .d_req         (dc_mem_req),
    .d_we          (dc_mem_we),
    .d_addr        (dc_mem_addr),
    .d_wline       (dc_mem_wline),
    .d_line        (dc_mem_rline),
    .d_ready       (dc_mem_ready),
    .mem_enable    (mem_enable),
    .mem_op        (mem_op),
    .mem_address   (mem_address),
    .mem_data_in   (mem_data_in),
    .mem_data_out  (mem_data_out),
    .mem_data_ready(mem_data_ready)
  );

  main_memory main_memory_i (
    .clk       (clk),
    .rst       (rst),
    .enable    (mem_enable),
    .op        (mem_op),
    .address   (mem_address),
    .data_in   (mem_data_in),
    .data_out  (mem_data_out),
    .data_ready(mem_data_ready)
  );

endmodule

`default_nettype wire

// ==== rtl/dcache.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"
`default_nettype none

module dcache (
  input  logic               clk,
  input  logic               rst,
  input  logic               data_req,
  input  logic               data_we,
  input  mem_pkg::mem_addr_t data_addr,
  input  mem_pkg::word_t     data_wdata,
  output logic               data_valid,
  output mem_pkg::word_t     data_rdata,
  output logic               mem_req,
  output logic               mem_we,
  output mem_pkg::mem_addr_t mem_addr,
  output mem_pkg::line_t     mem_wline,
  input  mem_pkg::line_t     mem_rline,
  input  logic               mem_ready
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_refill,
    st_write,
    st_respond
  } state_t;

  state_t state_q;

  mem_pkg::line_t          line_q [`CACHE_LINES];
  mem_pkg::tag_t           tag_q  [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid_q;

  // Request captured at accept time
  mem_pkg::mem_addr_t req_addr_q;
  logic               req_we_q;
  mem_pkg::word_t     req_wdata_q;

  // Merged line that goes out on the write-through
  mem_pkg::line_t wline_q;

  mem_pkg::index_t in_index;
  mem_pkg::index_t req_index;
  logic            in_hit;
  logic            req_hit;
  logic            accept;
  logic            fast_hit;
  logic            refill_done;

  assign in_index  = data_addr.cache_view.index;
  assign req_index = req_addr_q.cache_view.index;
  assign in_hit  = valid_q[in_index] && (tag_q[in_index] == data_addr.cache_view.tag);
  assign req_hit = valid_q[req_index] && (tag_q[req_index] == req_addr_q.cache_view.tag);

  // The cycle in which data_valid is high is skipped as in the icache
  assign accept      = (state_q == st_idle) && data_req && !data_valid;
  // Load hits answer straight from idle
  assign fast_hit    = accept && !data_we && in_hit;
  assign refill_done = (state_q == st_refill) && mem_ready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= st_idle;
      valid_q    <= '0;
      data_valid <= 1'b0;
    end
    else
    begin
      data_valid <= 1'b0;
      case (state_q)
        st_idle:
        begin
          if (fast_hit)
          begin
            data_valid <= 1'b1;
          end
          else if (accept)
          begin
            state_q <= st_lookup;
          end
        end
        st_lookup:
        begin
          // Only a store can hit here because load hits already answered from idle
          // Stores that hit skip the refill and go straight to memory
          if (!req_hit)
          begin
            state_q <= st_refill;
          end
          else
          begin
            state_q <= st_write;
          end
        end
        st_refill:
        begin
          if (mem_ready)
          begin
            valid_q[req_index] <= 1'b1;
            state_q <= req_we_q ? st_write : st_respond;
          end
        end
        st_write:
        begin
          if (mem_ready)
          begin
            state_q <= st_respond;
          end
        end
        default:
        begin
          data_valid <= 1'b1;
          state_q    <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req_addr_q  <= data_addr;
      req_we_q    <= data_we;
      req_wdata_q <= data_wdata;
      if (fast_hit)
      begin
        data_rdata <= mem_pkg::select_word(line_q[in_index], data_addr);
      end
    end
    if ((state_q == st_lookup) && req_hit)
    begin
      line_q[req_index] <= mem_pkg::merge_word(line_q[req_index], req_addr_q, req_wdata_q);
      wline_q <= mem_pkg::merge_word(line_q[req_index], req_addr_q, req_wdata_q);
    end
    if (refill_done)
    begin
      tag_q[req_index] <= req_addr_q.cache_view.tag;
      if (req_we_q)
      begin
        // On write-allocate the store word lands in the freshly read line
        line_q[req_index] <= mem_pkg::merge_word(mem_rline, req_addr_q, req_wdata_q);
        wline_q <= mem_pkg::merge_word(mem_rline, req_addr_q, req_wdata_q);
      end
      else
      begin
        line_q[req_index] <= mem_rline;
        data_rdata        <= mem_pkg::select_word(mem_rline, req_addr_q);
      end
    end
  end

  // Refill reads and write-through writes share one request line
  assign mem_req   = (state_q == st_refill) || (state_q == st_write);
  assign mem_we    = (state_q == st_write);
  assign mem_wline = wline_q;

  always_comb
  begin
    mem_addr = req_addr_q;
    mem_addr.cache_view.offset = '0;
  end

endmodule

`default_nettype wire

// ==== rtl/icache.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"
`default_nettype none

module icache (
  input  logic               clk,
  input  logic               rst,
  input  logic               fetch_req,
  input  mem_pkg::mem_addr_t fetch_addr,
  input  logic               flush,
  output logic               fetch_valid,
  output mem_pkg::word_t     fetch_word,
  output logic               mem_req,
  output mem_pkg::mem_addr_t mem_addr,
  input  mem_pkg::line_t     mem_rline,
  input  logic               mem_ready
);

  typedef enum logic {
    st_idle,
    st_miss
  } state_t;

  state_t state_q;

  mem_pkg::line_t          line_q [`CACHE_LINES];
  mem_pkg::tag_t           tag_q  [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid_q;

  // Fetch address captured when the request is taken
  mem_pkg::mem_addr_t req_addr_q;

  mem_pkg::index_t fetch_index;
  mem_pkg::index_t req_index;
  logic            hit;
  logic            accept;
  logic            fill;

  assign fetch_index = fetch_addr.cache_view.index;
  assign req_index   = req_addr_q.cache_view.index;
  assign hit = valid_q[fetch_index] && (tag_q[fetch_index] == fetch_addr.cache_view.tag);

  // While fetch_valid is high the requester still shows the old request
  assign accept = (state_q == st_idle) && fetch_req && !fetch_valid;
  assign fill   = (state_q == st_miss) && mem_ready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= st_idle;
      valid_q     <= '0;
      fetch_valid <= 1'b0;
    end
    else
    begin
      fetch_valid <= 1'b0;
      if (accept)
      begin
        if (hit)
        begin
          fetch_valid <= 1'b1;
        end
        else
        begin
          state_q <= st_miss;
        end
      end
      if (fill)
      begin
        valid_q[req_index] <= 1'b1;
        fetch_valid        <= 1'b1;
        state_q            <= st_idle;
      end
      // Flush comes last so it beats a fill in the same cycle
      if (flush)
      begin
        valid_q <= '0;
      end
    end
  end

  // Line storage and returned word
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req_addr_q <= fetch_addr;
      if (hit)
      begin
        fetch_word <= mem_pkg::select_word(line_q[fetch_index], fetch_addr);
      end
    end
    if (fill)
    begin
      line_q[req_index] <= mem_rline;
      tag_q[req_index]  <= req_addr_q.cache_view.tag;
      fetch_word        <= mem_pkg::select_word(mem_rline, req_addr_q);
    end
  end

  // Refill request, held until the arbiter returns the ready pulse
  assign mem_req = (state_q == st_miss);

  always_comb
  begin
    mem_addr = req_addr_q;
    mem_addr.cache_view.offset = '0;
  end

endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic               clk,
  input  logic               rst,
  // Instruction cache side, always a read
  input  logic               i_req,
  input  mem_pkg::mem_addr_t i_addr,
  output mem_pkg::line_t     i_line,
  output logic               i_ready,
  // Data cache side
  input  logic               d_req,
  input  logic               d_we,
  input  mem_pkg::mem_addr_t d_addr,
  input  mem_pkg::line_t     d_wline,
  output mem_pkg::line_t     d_line,
  output logic               d_ready,
  // Main memory side
  output logic               mem_enable,
  output logic               mem_op,
  output mem_pkg::mem_addr_t mem_address,
  output mem_pkg::line_t     mem_data_in,
  input  mem_pkg::line_t     mem_data_out,
  input  logic               mem_data_ready
);

  typedef enum logic [1:0] {
    own_none,
    own_icache,
    own_dcache
  } owner_t;

  owner_t owner_q;

  // High for the one empty cycle that follows every completed access
  logic release_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      owner_q   <= own_none;
      release_q <= 1'b0;
    end
    else
    begin
      release_q <= 1'b0;
      if (owner_q == own_none)
      begin
        // Data side wins a tie, nobody is granted in the release cycle
        if (!release_q)
        begin
          if (d_req)
          begin
            owner_q <= own_dcache;
          end
          else if (i_req)
          begin
            owner_q <= own_icache;
          end
        end
      end
      else if (mem_data_ready)
      begin
        owner_q   <= own_none;
        release_q <= 1'b1;
      end
    end
  end

  // Requests from the owner go straight to the memory
  assign mem_enable  = (owner_q != own_none);
  assign mem_op      = (owner_q == own_dcache) && d_we;
  assign mem_data_in = d_wline;

  // Memory only sees whole lines, the byte offset is forced to zero
  always_comb
  begin
    mem_address = (owner_q == own_dcache) ? d_addr : i_addr;
    mem_address.line_view.offset = '0;
  end

  // Read data is shared, the ready pulse goes only to the owner
  assign i_line  = mem_data_out;
  assign d_line  = mem_data_out;
  assign i_ready = mem_data_ready && (owner_q == own_icache);
  assign d_ready = mem_data_ready && (owner_q == own_dcache);

endmodule

`default_nettype wire

// ==== rtl/main_memory.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"
`default_nettype none

module main_memory (
  input  logic              clk,
  input  logic              rst,
  input  logic              enable,
  input  logic              op,
  input  mem_pkg::mem_addr_t address,
  input  mem_pkg::line_t    data_in,
  output mem_pkg::line_t    data_out,
  output logic              data_ready
);

  // One access walks through four states, so the next one starts no
  // earlier than four cycles after the previous start
  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_access,
    st_done
  } state_t;

  state_t state_q;

  // Byte storage, contents survive reset
  logic [7:0] bytes_q [`MEM_BYTES];

  // First byte of the addressed line
  logic [`MEM_ADDR_W-1:0] line_base;

  assign line_base = {address.line_view.line, {`OFFSET_W{1'b0}}};

  // Sequencer for the fixed latency
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= st_idle;
      data_ready <= 1'b0;
    end
    else
    begin
      data_ready <= 1'b0;
      case (state_q)
        st_idle:
        begin
          // Enable is only looked at here
          if (enable)
          begin
            state_q <= st_wait;
          end
        end
        st_wait:
        begin
          state_q <= st_access;
        end
        st_access:
        begin
          // The ready pulse lines up with the fresh read data
          data_ready <= 1'b1;
          state_q    <= st_done;
        end
        default:
        begin
          // Done cycle, a held enable must not restart an access here
          state_q <= st_idle;
        end
      endcase
    end
  end

  // Line transfer happens in the access state only
  always_ff @(posedge clk)
  begin
    if (state_q == st_access)
    begin
      for (int i = 0; i < `LINE_BYTES; i++)
      begin
        if (op)
        begin
          bytes_q[int'(line_base) + i] <= data_in[i*8 +: 8];
        end
        else
        begin
          data_out[i*8 +: 8] <= bytes_q[int'(line_base) + i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
`include "mem_defines.svh"
`default_nettype none

package mem_pkg;

  typedef logic [`LINE_W-1:0] line_t;
  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`TAG_W-1:0] tag_t;
  typedef logic [`INDEX_W-1:0] index_t;

  // Memory side of an address: a line number and the byte inside the line
  typedef struct packed {
    logic [`LINE_NUM_W-1:0] line;
    logic [`OFFSET_W-1:0]   offset;
  } addr_line_view_t;

  // Cache side of the same address
  typedef struct packed {
    tag_t                 tag;
    index_t               index;
    logic [`OFFSET_W-1:0] offset;
  } addr_cache_view_t;

  typedef union packed {
    addr_line_view_t  line_view;
    addr_cache_view_t cache_view;
  } mem_addr_t;

  // The upper offset bits pick one word out of the line
  function automatic word_t select_word(line_t line, mem_addr_t addr);
    return line[addr.cache_view.offset[`OFFSET_W-1 -: `WORD_SEL_W] * `WORD_W +: `WORD_W];
  endfunction

  // Returns the line with the addressed word replaced
  function automatic line_t merge_word(line_t line, mem_addr_t addr, word_t word);
    line_t merged;
    merged = line;
    merged[addr.cache_view.offset[`OFFSET_W-1 -: `WORD_SEL_W] * `WORD_W +: `WORD_W] = word;
    return merged;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

`default_nettype none

// Byte address width of the shared main memory
`define MEM_ADDR_W 12

// Total number of bytes held by the main memory
`define MEM_BYTES (1 << `MEM_ADDR_W)

// One cache line is moved per memory access
`define LINE_W 128
`define LINE_BYTES (`LINE_W / 8)

// Processor word width
`define WORD_W 32

// Lines per cache, both caches are the same size
`define CACHE_LINES 4

// Field widths of the two address views
`define OFFSET_W 4
`define WORD_SEL_W 2
`define INDEX_W 2
`define TAG_W (`MEM_ADDR_W - `INDEX_W - `OFFSET_W)
`define LINE_NUM_W (`MEM_ADDR_W - `OFFSET_W)

`default_nettype wire

`endif
